//--- source/rv_core_pkg.sv
// ==========================================================
// Shared widths, control encodings and instruction views of
// the RV32I integer core, referenced by scoped name
// ==========================================================
`default_nettype none

package rv_core_pkg;

	typedef logic [31:0] xlen_t;
	typedef logic [4:0]  reg_addr_t;

	// ==========================================================
	// Control encodings carried from decode to execute
	// ==========================================================

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} alu_op_e;

	typedef enum logic [1:0] {SRCA_RS1, SRCA_PC, SRCA_ZERO} src_a_e;

	// FOUR gives the link address as PC + 4 through the ALU
	typedef enum logic [1:0] {SRCB_RS2, SRCB_IMM, SRCB_FOUR} src_b_e;

	typedef enum logic [1:0] {BCOND_NEVER, BCOND_ALWAYS, BCOND_ZERO, BCOND_NZERO} bcond_e;

	typedef enum logic {JBASE_PC, JBASE_RS1} jbase_e;

	// ==========================================================
	// Instruction formats, MSB first
	// ==========================================================

	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		reg_addr_t  rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		reg_addr_t   rs1;
		logic [2:0]  funct3;
		reg_addr_t   rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		reg_addr_t   rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		reg_addr_t  rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// One word, six views
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} rv_instr_u;

	// Major opcodes
	localparam logic [6:0] OP_LUI      = 7'b0110111;
	localparam logic [6:0] OP_AUIPC    = 7'b0010111;
	localparam logic [6:0] OP_JAL      = 7'b1101111;
	localparam logic [6:0] OP_JALR     = 7'b1100111;
	localparam logic [6:0] OP_BRANCH   = 7'b1100011;
	localparam logic [6:0] OP_LOAD     = 7'b0000011;
	localparam logic [6:0] OP_STORE    = 7'b0100011;
	localparam logic [6:0] OP_IMM      = 7'b0010011;
	localparam logic [6:0] OP_REG      = 7'b0110011;
	localparam logic [6:0] OP_MISC_MEM = 7'b0001111;
	localparam logic [6:0] OP_SYSTEM   = 7'b1110011;

endpackage

`default_nettype wire

//--- source/rv_stage_if.sv
// ==========================================================
// Pipeline bundles between decode, register file, execute
// and the retire register
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

// Decode to execute, plus the register-file read ports
interface dx_if;
	logic                   valid;
	rv_core_pkg::reg_addr_t rs1;
	rv_core_pkg::reg_addr_t rs2;
	rv_core_pkg::reg_addr_t rd;
	rv_core_pkg::xlen_t     imm;
	rv_core_pkg::xlen_t     pc;
	rv_core_pkg::alu_op_e   alu_op;
	rv_core_pkg::src_a_e    src_a;
	rv_core_pkg::src_b_e    src_b;
	rv_core_pkg::bcond_e    bcond;
	rv_core_pkg::jbase_e    jbase;
	rv_core_pkg::xlen_t     rdata1;
	rv_core_pkg::xlen_t     rdata2;

	modport dec (output valid, rs1, rs2, rd, imm, pc, alu_op, src_a, src_b, bcond, jbase);
	modport rf  (input rs1, rs2, output rdata1, rdata2);
	modport exe (input valid, rs1, rs2, rd, imm, pc, alu_op, src_a, src_b, bcond, jbase,
		rdata1, rdata2);
endinterface

// Execute to retire; advance is the pipe-wide enable
interface xw_if;
	logic                   valid;
	rv_core_pkg::reg_addr_t rd;
	rv_core_pkg::xlen_t     result;
	logic                   jump;
	rv_core_pkg::xlen_t     target;
	logic                   advance;

	modport exe (output valid, rd, result, jump, target, input advance);
	modport ret (input valid, rd, result, jump, target, output advance);
endinterface

`default_nettype wire

//--- source/rv_alu.sv
// ==========================================================
// Integer ALU of the execute stage, purely combinational
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module rv_alu (
	input  wire rv_core_pkg::alu_op_e op_i,
	input  wire rv_core_pkg::xlen_t   a_i,
	input  wire rv_core_pkg::xlen_t   b_i,
	output rv_core_pkg::xlen_t        result_o,
	output logic                      zero_o
);

	// Shift amount from the low five bits only
	logic [4:0] shamt;

	assign shamt = b_i[4:0];

	always_comb begin
		case (op_i)
		rv_core_pkg::ALU_ADD:  result_o = a_i + b_i;
		rv_core_pkg::ALU_SUB:  result_o = a_i - b_i;
		rv_core_pkg::ALU_SLL:  result_o = a_i << shamt;
		rv_core_pkg::ALU_SLT:  result_o = {31'b0, $signed(a_i) < $signed(b_i)};
		rv_core_pkg::ALU_SLTU: result_o = {31'b0, a_i < b_i};
		rv_core_pkg::ALU_XOR:  result_o = a_i ^ b_i;
		rv_core_pkg::ALU_SRL:  result_o = a_i >> shamt;
		rv_core_pkg::ALU_SRA:  result_o = $signed(a_i) >>> shamt;
		rv_core_pkg::ALU_OR:   result_o = a_i | b_i;
		rv_core_pkg::ALU_AND:  result_o = a_i & b_i;
		default:               result_o = '0;
		endcase
	end

	// Branch conditions test this flag
	assign zero_o = (result_o == '0);

endmodule

`default_nettype wire

//--- source/rv_regfile.sv
// ==========================================================
// Two-read one-write register file, x0 hardwired to zero
// Reads are registered when the decode-to-execute stage loads
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
	input  wire                         clk,
	input  wire                         rst_n,
	dx_if.rf                            rf,
	input  wire                         load_i,
	input  wire                         wen_i,
	input  wire rv_core_pkg::reg_addr_t waddr_i,
	input  wire rv_core_pkg::xlen_t     wdata_i
);

	// x1..x31 only
	rv_core_pkg::xlen_t regs [1:31];

	// One read port, with bypass of a write on the same edge
	function automatic rv_core_pkg::xlen_t read_port(input rv_core_pkg::reg_addr_t addr);
		if (addr == '0) begin
			return '0;
		end else if (wen_i && addr == waddr_i) begin
			return wdata_i;
		end
		return regs[addr];
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen_i && waddr_i != '0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// Read data lines up with the D-to-X register
	always_ff @(posedge clk) begin
		if (load_i) begin
			rf.rdata1 <= read_port(rf.rs1);
			rf.rdata2 <= read_port(rf.rs2);
		end
	end

endmodule

`default_nettype wire

//--- source/rv_decode.sv
// ==========================================================
// Decode stage with the PC, the input handshake and the
// D-to-X register, holding input after control transfers
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module rv_decode #(
	parameter rv_core_pkg::xlen_t RESET_VECTOR = 32'h0000_0000
) (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         instr_valid_i,
	input  wire rv_core_pkg::rv_instr_u instr_i,
	output logic                        instr_ready_o,
	input  wire                         advance_i,
	input  wire                         jump_taken_i,
	input  wire rv_core_pkg::xlen_t     jump_target_i,
	dx_if.dec                           dx
);

	// Next PC to hand out, and the PC it resolves to this cycle
	rv_core_pkg::xlen_t     pc_q;
	rv_core_pkg::xlen_t     pc_sel;
	logic                   accept;
	// Instruction held in D
	logic                   d_valid;
	rv_core_pkg::rv_instr_u d_instr;
	rv_core_pkg::xlen_t     d_pc;
	// Decoded controls
	logic                   d_ctrl;
	logic                   d_wr_rd;
	rv_core_pkg::xlen_t     d_imm;
	rv_core_pkg::alu_op_e   d_alu_op;
	rv_core_pkg::src_a_e    d_src_a;
	rv_core_pkg::src_b_e    d_src_b;
	rv_core_pkg::bcond_e    d_bcond;
	rv_core_pkg::jbase_e    d_jbase;

	// funct3 to ALU op; alt selects SUB or SRA
	function automatic rv_core_pkg::alu_op_e alu_fn(input logic [2:0] funct3, input logic alt);
		case (funct3)
		3'b000:  return alt ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
		3'b001:  return rv_core_pkg::ALU_SLL;
		3'b010:  return rv_core_pkg::ALU_SLT;
		3'b011:  return rv_core_pkg::ALU_SLTU;
		3'b100:  return rv_core_pkg::ALU_XOR;
		3'b101:  return alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
		3'b110:  return rv_core_pkg::ALU_OR;
		default: return rv_core_pkg::ALU_AND;
		endcase
	endfunction

	// ==========================================================
	// Handshake and PC
	// ==========================================================

	// No new instruction while a jump or branch waits in D
	assign instr_ready_o = advance_i & ~(d_valid & d_ctrl);
	assign accept = instr_valid_i & instr_ready_o;
	// Jump resolving in X redirects the instruction accepted now
	assign pc_sel = jump_taken_i ? jump_target_i : pc_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q <= RESET_VECTOR;
			d_valid <= 1'b0;
		end else begin
			if (accept) begin
				pc_q <= pc_sel + 32'd4;
			end else if (jump_taken_i) begin
				pc_q <= jump_target_i;
			end
			if (advance_i) begin
				d_valid <= accept;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			d_instr <= instr_i;
			d_pc <= pc_sel;
		end
	end

	// ==========================================================
	// Opcode decode
	// ==========================================================

	always_comb begin
		// Register-immediate defaults
		d_imm = {{20{d_instr.i.imm_11_0[11]}}, d_instr.i.imm_11_0};
		d_alu_op = rv_core_pkg::ALU_ADD;
		d_src_a = rv_core_pkg::SRCA_RS1;
		d_src_b = rv_core_pkg::SRCB_IMM;
		d_bcond = rv_core_pkg::BCOND_NEVER;
		d_jbase = rv_core_pkg::JBASE_PC;
		d_wr_rd = 1'b1;
		d_ctrl = 1'b0;
		case (d_instr.r.opcode)
		rv_core_pkg::OP_LUI: begin
			d_imm = {d_instr.u.imm_31_12, 12'b0};
			d_src_a = rv_core_pkg::SRCA_ZERO;
		end
		rv_core_pkg::OP_AUIPC: begin
			d_imm = {d_instr.u.imm_31_12, 12'b0};
			d_src_a = rv_core_pkg::SRCA_PC;
		end
		rv_core_pkg::OP_JAL: begin
			d_imm = {{11{d_instr.j.imm_20}}, d_instr.j.imm_20, d_instr.j.imm_19_12,
				d_instr.j.imm_11, d_instr.j.imm_10_1, 1'b0};
			d_src_a = rv_core_pkg::SRCA_PC;
			d_src_b = rv_core_pkg::SRCB_FOUR;
			d_bcond = rv_core_pkg::BCOND_ALWAYS;
			d_ctrl = 1'b1;
		end
		rv_core_pkg::OP_JALR: begin
			// I immediate from the default, target based on rs1
			d_src_a = rv_core_pkg::SRCA_PC;
			d_src_b = rv_core_pkg::SRCB_FOUR;
			d_bcond = rv_core_pkg::BCOND_ALWAYS;
			d_jbase = rv_core_pkg::JBASE_RS1;
			d_ctrl = 1'b1;
		end
		rv_core_pkg::OP_BRANCH: begin
			d_imm = {{19{d_instr.b.imm_12}}, d_instr.b.imm_12, d_instr.b.imm_11,
				d_instr.b.imm_10_5, d_instr.b.imm_4_1, 1'b0};
			d_src_b = rv_core_pkg::SRCB_RS2;
			d_wr_rd = 1'b0;
			d_ctrl = 1'b1;
			// Compare in the ALU, then test zero or non-zero
			case (d_instr.b.funct3)
			3'b000: begin
				d_alu_op = rv_core_pkg::ALU_SUB;
				d_bcond = rv_core_pkg::BCOND_ZERO;
			end
			3'b001: begin
				d_alu_op = rv_core_pkg::ALU_SUB;
				d_bcond = rv_core_pkg::BCOND_NZERO;
			end
			3'b100, 3'b101: begin
				d_alu_op = rv_core_pkg::ALU_SLT;
				d_bcond = d_instr.b.funct3[0] ? rv_core_pkg::BCOND_ZERO : rv_core_pkg::BCOND_NZERO;
			end
			3'b110, 3'b111: begin
				d_alu_op = rv_core_pkg::ALU_SLTU;
				d_bcond = d_instr.b.funct3[0] ? rv_core_pkg::BCOND_ZERO : rv_core_pkg::BCOND_NZERO;
			end
			default: d_bcond = rv_core_pkg::BCOND_NEVER;
			endcase
		end
		rv_core_pkg::OP_IMM: begin
			// funct7 only qualifies right shifts here
			d_alu_op = alu_fn(d_instr.r.funct3,
				d_instr.r.funct7[5] & (d_instr.r.funct3 == 3'b101));
		end
		rv_core_pkg::OP_REG: begin
			d_alu_op = alu_fn(d_instr.r.funct3, d_instr.r.funct7[5]);
			d_src_b = rv_core_pkg::SRCB_RS2;
		end
		default: begin
			// Loads, stores, FENCE, SYSTEM and unknown encodings retire as no-ops
			d_wr_rd = 1'b0;
		end
		endcase
	end

	// ==========================================================
	// D-to-X register
	// ==========================================================

	// Source indices go straight to the register file
	assign dx.rs1 = d_instr.r.rs1;
	assign dx.rs2 = d_instr.r.rs2;

	// Bubble with no write and no jump when D is empty
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dx.valid <= 1'b0;
			dx.rd <= '0;
			dx.bcond <= rv_core_pkg::BCOND_NEVER;
		end else if (advance_i) begin
			dx.valid <= d_valid;
			dx.rd <= (d_valid && d_wr_rd) ? d_instr.r.rd : '0;
			dx.bcond <= d_valid ? d_bcond : rv_core_pkg::BCOND_NEVER;
		end
	end

	always_ff @(posedge clk) begin
		if (advance_i) begin
			dx.imm <= d_imm;
			dx.pc <= d_pc;
			dx.alu_op <= d_alu_op;
			dx.src_a <= d_src_a;
			dx.src_b <= d_src_b;
			dx.jbase <= d_jbase;
		end
	end

endmodule

`default_nettype wire

//--- source/rv_execute.sv
// ==========================================================
// Execute stage with forwarding, operand select, the ALU,
// branch resolution and the retire register
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module rv_execute (
	input  wire                 clk,
	input  wire                 rst_n,
	dx_if.exe                   dx,
	xw_if.exe                   xw,
	output logic                advance_o,
	output logic                jump_taken_o,
	output rv_core_pkg::xlen_t  jump_target_o
);

	// Source indices of the instruction now in X
	rv_core_pkg::reg_addr_t x_rs1;
	rv_core_pkg::reg_addr_t x_rs2;
	rv_core_pkg::xlen_t     rs1_val;
	rv_core_pkg::xlen_t     rs2_val;
	rv_core_pkg::xlen_t     op_a;
	rv_core_pkg::xlen_t     op_b;
	rv_core_pkg::xlen_t     alu_result;
	rv_core_pkg::xlen_t     target_sum;
	rv_core_pkg::xlen_t     target;
	logic                   alu_zero;
	logic                   taken;

	// Retire-register result wins over register-file data
	function automatic rv_core_pkg::xlen_t fwd(input rv_core_pkg::reg_addr_t idx,
		input rv_core_pkg::xlen_t rf_data, input rv_core_pkg::reg_addr_t w_rd,
		input rv_core_pkg::xlen_t w_data);
		if (idx == '0) begin
			return '0;
		end else if (idx == w_rd) begin
			return w_data;
		end
		return rf_data;
	endfunction

	// Whole pipe moves together
	assign advance_o = xw.advance;

	// Loads alongside the D-to-X register
	always_ff @(posedge clk) begin
		if (xw.advance) begin
			x_rs1 <= dx.rs1;
			x_rs2 <= dx.rs2;
		end
	end

	assign rs1_val = fwd(x_rs1, dx.rdata1, xw.rd, xw.result);
	assign rs2_val = fwd(x_rs2, dx.rdata2, xw.rd, xw.result);

	// Operand muxes
	always_comb begin
		case (dx.src_a)
		rv_core_pkg::SRCA_RS1: op_a = rs1_val;
		rv_core_pkg::SRCA_PC:  op_a = dx.pc;
		default:               op_a = '0;
		endcase
		case (dx.src_b)
		rv_core_pkg::SRCB_RS2:  op_b = rs2_val;
		rv_core_pkg::SRCB_IMM:  op_b = dx.imm;
		rv_core_pkg::SRCB_FOUR: op_b = 32'd4;
		default:                op_b = '0;
		endcase
	end

	rv_alu u_alu (
		.op_i     (dx.alu_op),
		.a_i      (op_a),
		.b_i      (op_b),
		.result_o (alu_result),
		.zero_o   (alu_zero)
	);

	// ==========================================================
	// Branch and jump resolution
	// ==========================================================

	always_comb begin
		case (dx.bcond)
		rv_core_pkg::BCOND_ALWAYS: taken = 1'b1;
		rv_core_pkg::BCOND_ZERO:   taken = alu_zero;
		rv_core_pkg::BCOND_NZERO:  taken = ~alu_zero;
		default:                   taken = 1'b0;
		endcase
	end

	assign target_sum = dx.imm + ((dx.jbase == rv_core_pkg::JBASE_RS1) ? rs1_val : dx.pc);
	// JALR clears bit 0
	assign target = {target_sum[31:1], target_sum[0] & (dx.jbase == rv_core_pkg::JBASE_PC)};

	// Redirect only on the edge the item moves on
	assign jump_taken_o = dx.valid & taken & xw.advance;
	assign jump_target_o = target;

	// ==========================================================
	// Retire register
	// ==========================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			xw.valid <= 1'b0;
			xw.rd <= '0;
			xw.jump <= 1'b0;
		end else if (xw.advance) begin
			xw.valid <= dx.valid;
			xw.rd <= dx.rd;
			xw.jump <= dx.valid & taken;
		end
	end

	always_ff @(posedge clk) begin
		if (xw.advance) begin
			xw.result <= alu_result;
			xw.target <= target;
		end
	end

endmodule

`default_nettype wire

//--- source/rv_int_core.sv
// ==========================================================
// RV32I integer core top that takes instructions in and
// hands out one retire item per instruction over valid/ready
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module rv_int_core #(
	parameter rv_core_pkg::xlen_t RESET_VECTOR = 32'h0000_0000
) (
	input  wire                         clk,
	input  wire                         rst_n,
	// Instruction input
	input  wire                         instr_valid_i,
	input  wire rv_core_pkg::xlen_t     instr_i,
	output logic                        instr_ready_o,
	// Retire output
	output logic                        retire_valid_o,
	input  wire                         retire_ready_i,
	output rv_core_pkg::reg_addr_t      retire_rd_o,
	output rv_core_pkg::xlen_t          retire_data_o,
	output logic                        retire_jump_o,
	output rv_core_pkg::xlen_t          retire_target_o
);

	logic               advance;
	logic               jump_taken;
	rv_core_pkg::xlen_t jump_target;
	logic               retire_fire;

	dx_if dx ();
	xw_if xw ();

	// Freeze everything while a retire item is refused
	assign xw.advance = ~(retire_valid_o & ~retire_ready_i);
	assign retire_fire = retire_valid_o & retire_ready_i;

	assign retire_valid_o = xw.valid;
	assign retire_rd_o = xw.rd;
	assign retire_data_o = xw.result;
	assign retire_jump_o = xw.jump;
	assign retire_target_o = xw.target;

	rv_decode #(
		.RESET_VECTOR (RESET_VECTOR)
	) u_decode (
		.clk           (clk),
		.rst_n         (rst_n),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.instr_ready_o (instr_ready_o),
		.advance_i     (advance),
		.jump_taken_i  (jump_taken),
		.jump_target_i (jump_target),
		.dx            (dx.dec)
	);

	rv_execute u_execute (
		.clk           (clk),
		.rst_n         (rst_n),
		.dx            (dx.exe),
		.xw            (xw.exe),
		.advance_o     (advance),
		.jump_taken_o  (jump_taken),
		.jump_target_o (jump_target)
	);

	// Write-back happens as the item leaves
	rv_regfile u_regfile (
		.clk     (clk),
		.rst_n   (rst_n),
		.rf      (dx.rf),
		.load_i  (advance),
		.wen_i   (retire_fire),
		.waddr_i (xw.rd),
		.wdata_i (xw.result)
	);

endmodule

`default_nettype wire

//--- tests/rv_int_core_assert.sv
// ==========================================================
// Handshake checks bound into the integer core top level
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module rv_int_core_assert (
	input wire                         clk,
	input wire                         rst_n,
	input wire                         instr_valid_i,
	input wire rv_core_pkg::xlen_t     instr_i,
	input wire                         instr_ready_i,
	input wire                         retire_valid_i,
	input wire                         retire_ready_i,
	input wire rv_core_pkg::reg_addr_t retire_rd_i,
	input wire rv_core_pkg::xlen_t     retire_data_i,
	input wire                         retire_jump_i,
	input wire rv_core_pkg::xlen_t     retire_target_i
);

	logic ctrl_accept;

	// JAL, JALR or a branch taken in on this edge
	assign ctrl_accept = instr_valid_i & instr_ready_i & ((instr_i[6:0] == rv_core_pkg::OP_JAL)
		|| (instr_i[6:0] == rv_core_pkg::OP_JALR) || (instr_i[6:0] == rv_core_pkg::OP_BRANCH));

	// Refused retire item keeps its payload
	retire_held: assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid_i && !retire_ready_i |=> retire_valid_i && $stable(retire_rd_i)
			&& $stable(retire_data_i) && $stable(retire_jump_i) && $stable(retire_target_i))
		else $error("Retire payload changed while held");

	// One cycle of hold after a control transfer
	ctrl_gap: assert property (@(posedge clk) disable iff (!rst_n)
		ctrl_accept |=> !instr_ready_i)
		else $error("Input ready right after a control transfer");

endmodule

bind rv_int_core rv_int_core_assert u_assert (
	.clk             (clk),
	.rst_n           (rst_n),
	.instr_valid_i   (instr_valid_i),
	.instr_i         (instr_i),
	.instr_ready_i   (instr_ready_o),
	.retire_valid_i  (retire_valid_o),
	.retire_ready_i  (retire_ready_i),
	.retire_rd_i     (retire_rd_o),
	.retire_data_i   (retire_data_o),
	.retire_jump_i   (retire_jump_o),
	.retire_target_i (retire_target_o)
);

`default_nettype wire

//--- tests/rv_int_core_tb.sv
// ==========================================================
// Testbench for the integer core that plays the program from
// the input file with random handshakes and checks retire items
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module rv_int_core_tb;

	localparam rv_core_pkg::xlen_t RESET_VECTOR = 32'h0000_0100;

	logic                   clk;
	logic                   rst_n;
	logic                   instr_valid_i;
	rv_core_pkg::xlen_t     instr_i;
	logic                   instr_ready_o;
	logic                   retire_valid_o;
	logic                   retire_ready_i;
	rv_core_pkg::reg_addr_t retire_rd_o;
	rv_core_pkg::xlen_t     retire_data_o;
	logic                   retire_jump_o;
	rv_core_pkg::xlen_t     retire_target_o;

	// Program and expected retire items, one entry per file line
	rv_core_pkg::xlen_t     exp_instr[$];
	rv_core_pkg::reg_addr_t exp_rd[$];
	rv_core_pkg::xlen_t     exp_data[$];
	logic                   exp_jump[$];
	rv_core_pkg::xlen_t     exp_target[$];

	logic [31:0] rng;
	int          sent;
	int          retired;
	int          extra;
	int          cycles;
	int          cycle_limit;
	int          word_errors;
	int          reg_errors;
	int          flag_errors;
	int          other_errors;

	rv_int_core #(
		.RESET_VECTOR (RESET_VECTOR)
	) u_rv_int_core (
		.clk             (clk),
		.rst_n           (rst_n),
		.instr_valid_i   (instr_valid_i),
		.instr_i         (instr_i),
		.instr_ready_o   (instr_ready_o),
		.retire_valid_o  (retire_valid_o),
		.retire_ready_i  (retire_ready_i),
		.retire_rd_o     (retire_rd_o),
		.retire_data_o   (retire_data_o),
		.retire_jump_o   (retire_jump_o),
		.retire_target_o (retire_target_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ==========================================================
	// Random stream and compare tasks
	// ==========================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_word(input string what, input rv_core_pkg::xlen_t got,
		input rv_core_pkg::xlen_t exp);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
			word_errors++;
		end
	endtask

	task automatic check_reg(input string what, input rv_core_pkg::reg_addr_t got,
		input rv_core_pkg::reg_addr_t exp);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
			reg_errors++;
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
			flag_errors++;
		end
	endtask

	// Columns are instruction, rd, data, jump flag and target
	task automatic load_vectors();
		int          fd;
		int          fields;
		string       line;
		logic [31:0] f_instr;
		logic [31:0] f_rd;
		logic [31:0] f_data;
		logic [31:0] f_jump;
		logic [31:0] f_target;
		fd = $fopen("tests/rv_int_core_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open the input file tests/rv_int_core_input.txt");
			other_errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			// Comment and blank lines give no fields
			fields = $sscanf(line, "%h %h %h %h %h", f_instr, f_rd, f_data, f_jump, f_target);
			if (fields == 5) begin
				exp_instr.push_back(f_instr);
				exp_rd.push_back(f_rd[4:0]);
				exp_data.push_back(f_data);
				exp_jump.push_back(f_jump[0]);
				exp_target.push_back(f_target);
			end
		end
		$fclose(fd);
	endtask

	// ==========================================================
	// Per-edge handshake work
	// ==========================================================

	// Item leaving on this edge against the next expected one
	task automatic take_retire();
		if (retire_valid_o && retire_ready_i) begin
			check_reg($sformatf("item %0d rd", retired), retire_rd_o, exp_rd[retired]);
			check_flag($sformatf("item %0d jump", retired), retire_jump_o, exp_jump[retired]);
			if (exp_rd[retired] != '0) begin
				check_word($sformatf("item %0d data", retired), retire_data_o,
					exp_data[retired]);
			end
			if (exp_jump[retired]) begin
				check_word($sformatf("item %0d target", retired), retire_target_o,
					exp_target[retired]);
			end
			retired++;
		end
	endtask

	task automatic drive_inputs();
		if (instr_valid_i && instr_ready_o) begin
			sent++;
		end
		rng = xorshift32(rng);
		// Offer held until taken
		if (!instr_valid_i || instr_ready_o) begin
			if (sent < exp_instr.size() && rng[3:2] != 2'b00) begin
				instr_valid_i <= 1'b1;
				instr_i <= exp_instr[sent];
			end else begin
				instr_valid_i <= 1'b0;
			end
		end
		retire_ready_i <= (rng[17:16] != 2'b00);
	endtask

	// ==========================================================
	// Main sequence
	// ==========================================================

	initial begin
		rst_n = 1'b0;
		instr_valid_i = 1'b0;
		instr_i = '0;
		retire_ready_i = 1'b0;
		rng = 32'hdfa1ef16;
		sent = 0;
		retired = 0;
		extra = 0;
		cycles = 0;
		word_errors = 0;
		reg_errors = 0;
		flag_errors = 0;
		other_errors = 0;
		load_vectors();
		if (exp_instr.size() == 0) begin
			$display("No instructions were read from the input file");
			other_errors++;
		end
		// Eight cycles per instruction plus slack for reset and drain
		cycle_limit = 8 * exp_instr.size() + 100;

		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		while (retired < exp_instr.size() && cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
			take_retire();
			drive_inputs();
		end

		if (retired < exp_instr.size()) begin
			$display("Timeout after %0d cycles with %0d of %0d instructions retired",
				cycles, retired, exp_instr.size());
			other_errors++;
		end else begin
			// Nothing more may leave once the program is done
			instr_valid_i <= 1'b0;
			retire_ready_i <= 1'b1;
			repeat (10) begin
				@(posedge clk);
				if (retire_valid_o && retire_ready_i) begin
					extra++;
				end
			end
			if (extra != 0) begin
				$display("%0d retire items arrived beyond the end of the program", extra);
				other_errors++;
			end
		end

		$display("Errors: word %0d, reg %0d, flag %0d, other %0d",
			word_errors, reg_errors, flag_errors, other_errors);
		if (word_errors + reg_errors + flag_errors + other_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/rv_int_core_input.txt
// instr    rd data     jump target   (all hex, one instruction per line)
// first instruction at pc 00000100, lines in execution order
00500093 01 00000005 0 00000000
fff0c113 02 fffffffa 0 00000000
00012193 03 00000001 0 00000000
40115213 04 fffffffd 0 00000000
004082b3 05 00000002 0 00000000
40128333 06 fffffffd 0 00000000
0060b3b3 07 00000001 0 00000000
00709433 08 0000000a 0 00000000
00708013 00 00000000 0 00000000
001004b3 09 00000005 0 00000000
00908463 00 00000000 1 00000130
00909863 00 00000000 0 00000000
fe114ce3 00 00000000 1 0000012c
0020f663 00 00000000 0 00000000
00117663 00 00000000 1 0000013c
0020c463 00 00000000 0 00000000
0100056f 0a 00000144 1 00000150
123455b7 0b 12345000 0 00000000
00001617 0c 00001154 0 00000000
801606e7 0d 0000015c 1 00000954
01068713 0e 0000016c 0 00000000
0ff0000f 00 00000000 0 00000000
00112023 00 00000000 0 00000000
02a71063 00 00000000 1 00000980
00000797 0f 00000980 0 00000000
00e78833 10 00000aec 0 00000000

//--- rv_int_core.f
source/rv_core_pkg.sv
source/rv_stage_if.sv
source/rv_alu.sv
source/rv_regfile.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_int_core.sv
tests/rv_int_core_assert.sv
tests/rv_int_core_tb.sv

//--- Makefile
SIM  = obj_dir/Vrv_int_core_tb
SRCS = $(shell cat rv_int_core.f)

.PHONY: all run clean

all: $(SIM)

$(SIM): rv_int_core.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module rv_int_core_tb -f rv_int_core.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf obj_dir
